/* verilog/mcu_settings.svh */
// Bus widths, address map and register offsets of the MCU bus slice
// Included by the package, the RTL and the testbench
`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

`define MCU_DATA_W 32
`define MCU_ADDR_W 16

`define MCU_RAM_WORDS 256
`define MCU_RAM_BASE 16'h0000
`define MCU_PERIPH_BASE 16'h1000

// Byte offsets inside the 32 byte peripheral window
`define MCU_REG_GPIO_OUT 5'h00
`define MCU_REG_GPIO_OE 5'h04
`define MCU_REG_GPIO_IN 5'h08
`define MCU_REG_EXIT 5'h0C
`define MCU_REG_DMA_SRC 5'h10
`define MCU_REG_DMA_DST 5'h14
`define MCU_REG_DMA_LEN 5'h18
`define MCU_REG_DMA_STATUS 5'h1C

`define MCU_GPIO_W 8
`define MCU_BUS_ERR_DATA 32'hbadcab1e

`endif

/* verilog/mcu_pkg.sv */
// Word, address and FSM types shared by the bus masters and the arbiter
`include "mcu_settings.svh"

package mcu_pkg;

  typedef logic [`MCU_DATA_W-1:0] word_t;
  typedef logic [`MCU_ADDR_W-1:0] addr_t;

  // Decoded target of one access
  typedef enum logic [1:0] {
    TGT_RAM    = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_NONE   = 2'd2
  } bus_target_e;

  typedef enum logic [1:0] {
    ARB_IDLE   = 2'd0,
    ARB_ACCESS = 2'd1,
    ARB_ACK    = 2'd2
  } arb_state_e;

  typedef enum logic [1:0] {
    DMA_IDLE    = 2'd0,
    DMA_READ    = 2'd1,
    DMA_WRITE   = 2'd2,
    DMA_RELEASE = 2'd3
  } dma_state_e;

endpackage

/* verilog/bus_arbiter.sv */
// Two-master arbiter for the shared bus with four-phase req/ack per master
// Decodes each access to the RAM, the peripheral window or an error response
`timescale 1ns/1ps
`include "mcu_settings.svh"

module bus_arbiter (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              m0_req_i,
  input  logic                              m0_we_i,
  input  mcu_pkg::addr_t                    m0_addr_i,
  input  mcu_pkg::word_t                    m0_wdata_i,
  output logic                              m0_ack_o,
  output mcu_pkg::word_t                    m0_rdata_o,
  input  logic                              m1_req_i,
  input  logic                              m1_we_i,
  input  mcu_pkg::addr_t                    m1_addr_i,
  input  mcu_pkg::word_t                    m1_wdata_i,
  output logic                              m1_ack_o,
  output mcu_pkg::word_t                    m1_rdata_o,
  output logic                              ram_en_o,
  output logic                              ram_we_o,
  output logic [$clog2(`MCU_RAM_WORDS)-1:0] ram_word_addr_o,
  output mcu_pkg::word_t                    ram_wdata_o,
  input  mcu_pkg::word_t                    ram_rdata_i,
  output logic                              periph_en_o,
  output logic                              periph_we_o,
  output logic [4:0]                        periph_offset_o,
  output mcu_pkg::word_t                    periph_wdata_o,
  input  mcu_pkg::word_t                    periph_rdata_i
);

  localparam int RAM_AW = $clog2(`MCU_RAM_WORDS);
  localparam mcu_pkg::addr_t RAM_MASK = ~mcu_pkg::addr_t'(4 * `MCU_RAM_WORDS - 1);
  localparam mcu_pkg::addr_t PERIPH_MASK = ~mcu_pkg::addr_t'(31);

  mcu_pkg::arb_state_e  state;
  mcu_pkg::bus_target_e sel_tgt;
  mcu_pkg::bus_target_e cur_tgt;
  mcu_pkg::addr_t       sel_addr;
  mcu_pkg::addr_t       cur_addr;
  mcu_pkg::addr_t       bus_addr;
  mcu_pkg::word_t       sel_wdata;
  mcu_pkg::word_t       rdata_mux;
  logic [1:0]           req_q;
  logic                 sel_we;
  logic                 cur_we;
  logic                 win;
  logic                 gnt;
  logic                 last_gnt;
  logic                 grant;

  function automatic mcu_pkg::bus_target_e decode(input mcu_pkg::addr_t addr);
    if ((addr & RAM_MASK) == `MCU_RAM_BASE) begin
      return mcu_pkg::TGT_RAM;
    end else if ((addr & PERIPH_MASK) == `MCU_PERIPH_BASE) begin
      return mcu_pkg::TGT_PERIPH;
    end
    return mcu_pkg::TGT_NONE;
  endfunction

  // Less recently served master wins a tie
  always_comb begin
    if (&req_q) begin
      win = ~last_gnt;
    end else begin
      win = req_q[1];
    end
  end

  assign grant     = (state == mcu_pkg::ARB_IDLE) && (|req_q);
  assign sel_we    = win ? m1_we_i : m0_we_i;
  assign sel_addr  = win ? m1_addr_i : m0_addr_i;
  assign sel_wdata = win ? m1_wdata_i : m0_wdata_i;
  assign sel_tgt   = decode(sel_addr);

  // Target is strobed in the grant cycle, the latched address keeps the read path
  assign bus_addr = (state == mcu_pkg::ARB_IDLE) ? sel_addr : cur_addr;

  assign ram_en_o        = grant && (sel_tgt == mcu_pkg::TGT_RAM);
  assign ram_we_o        = sel_we;
  assign ram_word_addr_o = bus_addr[RAM_AW+1:2];
  assign ram_wdata_o     = sel_wdata;

  assign periph_en_o     = grant && (sel_tgt == mcu_pkg::TGT_PERIPH);
  assign periph_we_o     = sel_we;
  assign periph_offset_o = bus_addr[4:0];
  assign periph_wdata_o  = sel_wdata;

  always_comb begin
    case (cur_tgt)
      mcu_pkg::TGT_RAM:    rdata_mux = ram_rdata_i;
      mcu_pkg::TGT_PERIPH: rdata_mux = periph_rdata_i;
      default:             rdata_mux = `MCU_BUS_ERR_DATA;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state    <= mcu_pkg::ARB_IDLE;
      req_q    <= 2'b00;
      gnt      <= 1'b0;
      last_gnt <= 1'b1;
      cur_we   <= 1'b0;
      cur_tgt  <= mcu_pkg::TGT_NONE;
      m0_ack_o <= 1'b0;
      m1_ack_o <= 1'b0;
    end else begin
      req_q <= {m1_req_i, m0_req_i};
      case (state)
        mcu_pkg::ARB_IDLE: begin
          if (grant) begin
            gnt      <= win;
            last_gnt <= win;
            cur_we   <= sel_we;
            cur_tgt  <= sel_tgt;
            state    <= mcu_pkg::ARB_ACCESS;
          end
        end
        mcu_pkg::ARB_ACCESS: begin
          if (gnt) begin
            m1_ack_o <= 1'b1;
          end else begin
            m0_ack_o <= 1'b1;
          end
          state <= mcu_pkg::ARB_ACK;
        end
        mcu_pkg::ARB_ACK: begin
          // Hold until the served master has let go of req
          if (!req_q[gnt]) begin
            m0_ack_o <= 1'b0;
            m1_ack_o <= 1'b0;
            state    <= mcu_pkg::ARB_IDLE;
          end
        end
        default: state <= mcu_pkg::ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      cur_addr <= sel_addr;
    end
    if (state == mcu_pkg::ARB_ACCESS && !cur_we) begin
      if (gnt) begin
        m1_rdata_o <= rdata_mux;
      end else begin
        m0_rdata_o <= rdata_mux;
      end
    end
  end

endmodule

/* verilog/ram_bank.sv */
// Single-port word memory behind the arbiter
// Read data appears on the cycle after the enable
`timescale 1ns/1ps
`include "mcu_settings.svh"

module ram_bank (
  input  logic                              clk_i,
  input  logic                              en_i,
  input  logic                              we_i,
  input  logic [$clog2(`MCU_RAM_WORDS)-1:0] word_addr_i,
  input  mcu_pkg::word_t                    wdata_i,
  output mcu_pkg::word_t                    rdata_o
);

  mcu_pkg::word_t mem [`MCU_RAM_WORDS];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[word_addr_i] <= wdata_i;
      end else begin
        // Output holds its value between reads
        rdata_o <= mem[word_addr_i];
      end
    end
  end

endmodule

/* verilog/ao_peripherals.sv */
// Always-on register block: GPIO, exit value and DMA configuration
// Reads are combinational, writes land on the edge of the bus access
`timescale 1ns/1ps
`include "mcu_settings.svh"

module ao_peripherals (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   en_i,
  input  logic                   we_i,
  input  logic [4:0]             offset_i,
  input  mcu_pkg::word_t         wdata_i,
  output mcu_pkg::word_t         rdata_o,
  input  logic [`MCU_GPIO_W-1:0] gpio_i,
  output logic [`MCU_GPIO_W-1:0] gpio_o,
  output logic [`MCU_GPIO_W-1:0] gpio_oe_o,
  output logic                   exit_valid_o,
  output mcu_pkg::word_t         exit_value_o,
  output logic                   dma_start_o,
  output mcu_pkg::addr_t         dma_src_o,
  output mcu_pkg::addr_t         dma_dst_o,
  output mcu_pkg::addr_t         dma_len_o,
  input  logic                   dma_busy_i
);

  logic [`MCU_GPIO_W-1:0] gpio_meta;
  logic [`MCU_GPIO_W-1:0] gpio_sync;
  logic [4:0]             reg_sel;
  logic                   wr;
  logic                   len_wr;

  // Low two bits of the offset are ignored
  assign reg_sel = {offset_i[4:2], 2'b00};
  assign wr      = en_i && we_i;
  assign len_wr  = wr && (reg_sel == `MCU_REG_DMA_LEN) && !dma_busy_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_meta    <= '0;
      gpio_sync    <= '0;
      gpio_o       <= '0;
      gpio_oe_o    <= '0;
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
      dma_start_o  <= 1'b0;
      dma_src_o    <= '0;
      dma_dst_o    <= '0;
      dma_len_o    <= '0;
    end else begin
      gpio_meta   <= gpio_i;
      gpio_sync   <= gpio_meta;
      dma_start_o <= len_wr && (wdata_i[`MCU_ADDR_W-1:0] != '0);
      if (len_wr) begin
        dma_len_o <= wdata_i[`MCU_ADDR_W-1:0];
      end
      if (wr) begin
        case (reg_sel)
          `MCU_REG_GPIO_OUT: gpio_o <= wdata_i[`MCU_GPIO_W-1:0];
          `MCU_REG_GPIO_OE:  gpio_oe_o <= wdata_i[`MCU_GPIO_W-1:0];
          `MCU_REG_EXIT: begin
            exit_value_o <= wdata_i;
            exit_valid_o <= 1'b1;
          end
          `MCU_REG_DMA_SRC:  dma_src_o <= wdata_i[`MCU_ADDR_W-1:0];
          `MCU_REG_DMA_DST:  dma_dst_o <= wdata_i[`MCU_ADDR_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (reg_sel)
      `MCU_REG_GPIO_OUT:   rdata_o = mcu_pkg::word_t'(gpio_o);
      `MCU_REG_GPIO_OE:    rdata_o = mcu_pkg::word_t'(gpio_oe_o);
      `MCU_REG_GPIO_IN:    rdata_o = mcu_pkg::word_t'(gpio_sync);
      `MCU_REG_EXIT:       rdata_o = exit_value_o;
      `MCU_REG_DMA_SRC:    rdata_o = mcu_pkg::word_t'(dma_src_o);
      `MCU_REG_DMA_DST:    rdata_o = mcu_pkg::word_t'(dma_dst_o);
      `MCU_REG_DMA_LEN:    rdata_o = mcu_pkg::word_t'(dma_len_o);
      `MCU_REG_DMA_STATUS: rdata_o = mcu_pkg::word_t'(dma_busy_i);
      default:             rdata_o = '0;
    endcase
  end

endmodule

/* verilog/dma_engine.sv */
// Word copy engine, second master on the shared bus
// One read then one write per word, both as full four-phase handshakes
`timescale 1ns/1ps

module dma_engine (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           start_i,
  input  mcu_pkg::addr_t src_i,
  input  mcu_pkg::addr_t dst_i,
  input  mcu_pkg::addr_t len_i,
  output logic           busy_o,
  output logic           req_o,
  output logic           we_o,
  output mcu_pkg::addr_t addr_o,
  output mcu_pkg::word_t wdata_o,
  input  logic           ack_i,
  input  mcu_pkg::word_t rdata_i
);

  localparam mcu_pkg::addr_t WORD_STEP = 4;
  localparam mcu_pkg::addr_t ONE_WORD = 1;

  mcu_pkg::dma_state_e state;
  mcu_pkg::addr_t      src;
  mcu_pkg::addr_t      dst;
  mcu_pkg::addr_t      remain;
  mcu_pkg::word_t      data;

  assign we_o    = (state == mcu_pkg::DMA_WRITE);
  assign addr_o  = we_o ? dst : src;
  assign wdata_o = data;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state  <= mcu_pkg::DMA_IDLE;
      req_o  <= 1'b0;
      busy_o <= 1'b0;
      src    <= '0;
      dst    <= '0;
      remain <= '0;
    end else begin
      case (state)
        mcu_pkg::DMA_IDLE: begin
          if (start_i) begin
            src    <= src_i;
            dst    <= dst_i;
            remain <= len_i;
            busy_o <= 1'b1;
            state  <= mcu_pkg::DMA_READ;
          end
        end
        mcu_pkg::DMA_READ: begin
          // New req only once the previous ack has gone
          if (!req_o && !ack_i) begin
            req_o <= 1'b1;
          end else if (req_o && ack_i) begin
            req_o <= 1'b0;
            state <= mcu_pkg::DMA_WRITE;
          end
        end
        mcu_pkg::DMA_WRITE: begin
          if (!req_o && !ack_i) begin
            req_o <= 1'b1;
          end else if (req_o && ack_i) begin
            req_o  <= 1'b0;
            src    <= src + WORD_STEP;
            dst    <= dst + WORD_STEP;
            remain <= remain - ONE_WORD;
            if (remain == ONE_WORD) begin
              state <= mcu_pkg::DMA_RELEASE;
            end else begin
              state <= mcu_pkg::DMA_READ;
            end
          end
        end
        mcu_pkg::DMA_RELEASE: begin
          // Wait for the last ack to drop
          if (!ack_i) begin
            busy_o <= 1'b0;
            state  <= mcu_pkg::DMA_IDLE;
          end
        end
        default: state <= mcu_pkg::DMA_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == mcu_pkg::DMA_READ && req_o && ack_i) begin
      data <= rdata_i;
    end
  end

endmodule

/* verilog/mcu_top.sv */
// Top of the MCU bus slice: host port as master 0, DMA as master 1
// The host port follows the same four-phase handshake as the arbiter
`timescale 1ns/1ps
`include "mcu_settings.svh"

module mcu_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   host_req_i,
  input  logic                   host_we_i,
  input  mcu_pkg::addr_t         host_addr_i,
  input  mcu_pkg::word_t         host_wdata_i,
  output logic                   host_ack_o,
  output mcu_pkg::word_t         host_rdata_o,
  input  logic [`MCU_GPIO_W-1:0] gpio_i,
  output logic [`MCU_GPIO_W-1:0] gpio_o,
  output logic [`MCU_GPIO_W-1:0] gpio_oe_o,
  output logic                   exit_valid_o,
  output mcu_pkg::word_t         exit_value_o
);

  logic                              ram_en;
  logic                              ram_we;
  logic [$clog2(`MCU_RAM_WORDS)-1:0] ram_word_addr;
  mcu_pkg::word_t                    ram_wdata;
  mcu_pkg::word_t                    ram_rdata;
  logic                              periph_en;
  logic                              periph_we;
  logic [4:0]                        periph_offset;
  mcu_pkg::word_t                    periph_wdata;
  mcu_pkg::word_t                    periph_rdata;
  logic                              dma_start;
  logic                              dma_busy;
  mcu_pkg::addr_t                    dma_src;
  mcu_pkg::addr_t                    dma_dst;
  mcu_pkg::addr_t                    dma_len;
  logic                              dma_req;
  logic                              dma_we;
  mcu_pkg::addr_t                    dma_addr;
  mcu_pkg::word_t                    dma_wdata;
  logic                              dma_ack;
  mcu_pkg::word_t                    dma_rdata;

  bus_arbiter u_bus_arbiter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .m0_req_i        (host_req_i),
    .m0_we_i         (host_we_i),
    .m0_addr_i       (host_addr_i),
    .m0_wdata_i      (host_wdata_i),
    .m0_ack_o        (host_ack_o),
    .m0_rdata_o      (host_rdata_o),
    .m1_req_i        (dma_req),
    .m1_we_i         (dma_we),
    .m1_addr_i       (dma_addr),
    .m1_wdata_i      (dma_wdata),
    .m1_ack_o        (dma_ack),
    .m1_rdata_o      (dma_rdata),
    .ram_en_o        (ram_en),
    .ram_we_o        (ram_we),
    .ram_word_addr_o (ram_word_addr),
    .ram_wdata_o     (ram_wdata),
    .ram_rdata_i     (ram_rdata),
    .periph_en_o     (periph_en),
    .periph_we_o     (periph_we),
    .periph_offset_o (periph_offset),
    .periph_wdata_o  (periph_wdata),
    .periph_rdata_i  (periph_rdata)
  );

  ram_bank u_ram_bank (
    .clk_i       (clk_i),
    .en_i        (ram_en),
    .we_i        (ram_we),
    .word_addr_i (ram_word_addr),
    .wdata_i     (ram_wdata),
    .rdata_o     (ram_rdata)
  );

  ao_peripherals u_ao_peripherals (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .en_i         (periph_en),
    .we_i         (periph_we),
    .offset_i     (periph_offset),
    .wdata_i      (periph_wdata),
    .rdata_o      (periph_rdata),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_oe_o    (gpio_oe_o),
    .exit_valid_o (exit_valid_o),
    .exit_value_o (exit_value_o),
    .dma_start_o  (dma_start),
    .dma_src_o    (dma_src),
    .dma_dst_o    (dma_dst),
    .dma_len_o    (dma_len),
    .dma_busy_i   (dma_busy)
  );

  dma_engine u_dma_engine (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (dma_start),
    .src_i   (dma_src),
    .dst_i   (dma_dst),
    .len_i   (dma_len),
    .busy_o  (dma_busy),
    .req_o   (dma_req),
    .we_o    (dma_we),
    .addr_o  (dma_addr),
    .wdata_o (dma_wdata),
    .ack_i   (dma_ack),
    .rdata_i (dma_rdata)
  );

endmodule

/* sim/tb_clock_gen.sv */
// Clock and reset source for the MCU testbench
// 20 ns clock, reset held low for the first 10 cycles
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

  // Release on a falling edge, away from the flops
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* sim/tb_mcu_top.sv */
// Directed tests for the MCU bus slice through the host port
// Inputs change on the falling clock edge, outputs are sampled there too
`timescale 1ns/1ps
`include "mcu_settings.svh"

module tb_mcu_top;

  localparam int NUM_TESTS = 6;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int RAM_TEST_WORDS = 32;
  localparam int DMA_WORDS = 16;

  logic                   clk;
  logic                   rst_n;
  logic                   host_req;
  logic                   host_we;
  mcu_pkg::addr_t         host_addr;
  mcu_pkg::word_t         host_wdata;
  logic                   host_ack;
  mcu_pkg::word_t         host_rdata;
  logic [`MCU_GPIO_W-1:0] gpio_in;
  logic [`MCU_GPIO_W-1:0] gpio_out;
  logic [`MCU_GPIO_W-1:0] gpio_oe;
  logic                   exit_valid;
  mcu_pkg::word_t         exit_value;
  logic [31:0]            lfsr_state;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mcu_top u_mcu_top (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_ack_o   (host_ack),
    .host_rdata_o (host_rdata),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_oe_o    (gpio_oe),
    .exit_valid_o (exit_valid),
    .exit_value_o (exit_value)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int nbits, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < nbits; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic mcu_pkg::addr_t ram_addr(input int idx);
    return mcu_pkg::addr_t'(`MCU_RAM_BASE + 4 * idx);
  endfunction

  function automatic mcu_pkg::addr_t periph_reg(input logic [4:0] offset);
    return `MCU_PERIPH_BASE | mcu_pkg::addr_t'(offset);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic wait_ack_high;
    @(negedge clk);
    while (!host_ack) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_ack_low;
    while (host_ack) begin
      @(negedge clk);
    end
  endtask

  task automatic bus_write(input mcu_pkg::addr_t addr, input mcu_pkg::word_t data);
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    wait_ack_high();
    host_req = 1'b0;
    wait_ack_low();
  endtask

  task automatic bus_read(input mcu_pkg::addr_t addr, output mcu_pkg::word_t data);
    @(negedge clk);
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = addr;
    wait_ack_high();
    data     = host_rdata;
    host_req = 1'b0;
    wait_ack_low();
  endtask

  task automatic start_copy(input int src_word, input int dst_word, input int words);
    bus_write(periph_reg(`MCU_REG_DMA_SRC), 32'(ram_addr(src_word)));
    bus_write(periph_reg(`MCU_REG_DMA_DST), 32'(ram_addr(dst_word)));
    bus_write(periph_reg(`MCU_REG_DMA_LEN), words);
  endtask

  task automatic wait_dma_idle;
    mcu_pkg::word_t status;
    bus_read(periph_reg(`MCU_REG_DMA_STATUS), status);
    while (status[0]) begin
      bus_read(periph_reg(`MCU_REG_DMA_STATUS), status);
    end
  endtask

  task automatic test_handshake;
    mcu_pkg::word_t data;
    mcu_pkg::word_t rdata;
    int cycles;
    check_eq("host_ack_o", 32'(host_ack), 32'h0);
    check_eq("exit_valid_o", 32'(exit_valid), 32'h0);
    check_eq("gpio_oe_o", 32'(gpio_oe), 32'h0);
    rand_bits(32, data);
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = ram_addr(5);
    host_wdata = data;
    cycles = 0;
    wait_ack_high_counted(cycles);
    // Idle bus: one cycle to sample req, one in ARB_ACCESS, then ack
    check_eq("host_ack_o rise latency", cycles, 3);
    repeat (5) begin
      @(negedge clk);
      check_eq("host_ack_o", 32'(host_ack), 32'h1);
    end
    host_req = 1'b0;
    cycles = 0;
    while (host_ack && cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    check_eq("host_ack_o fall latency", cycles, 2);
    bus_read(ram_addr(5), rdata);
    check_eq("host_rdata_o", rdata, data);
  endtask

  task automatic wait_ack_high_counted(inout int cycles);
    @(negedge clk);
    cycles++;
    while (!host_ack) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic test_ram;
    logic [`MCU_RAM_WORDS-1:0] used;
    int                        words [RAM_TEST_WORDS];
    mcu_pkg::word_t            values [RAM_TEST_WORDS];
    logic [31:0]               rnd;
    mcu_pkg::word_t            data;
    int                        n;
    used = '0;
    n = 0;
    // Distinct word addresses only
    while (n < RAM_TEST_WORDS) begin
      rand_bits(8, rnd);
      if (!used[rnd[7:0]]) begin
        used[rnd[7:0]] = 1'b1;
        words[n] = int'(rnd[7:0]);
        rand_bits(32, rnd);
        values[n] = rnd;
        n++;
      end
    end
    for (n = 0; n < RAM_TEST_WORDS; n++) begin
      bus_write(ram_addr(words[n]), values[n]);
    end
    for (n = 0; n < RAM_TEST_WORDS; n++) begin
      bus_read(ram_addr(words[n]), data);
      check_eq("host_rdata_o", data, values[n]);
    end
    bus_read(16'h0400, data);
    check_eq("host_rdata_o unmapped", data, `MCU_BUS_ERR_DATA);
    bus_read(16'h8000, data);
    check_eq("host_rdata_o unmapped", data, `MCU_BUS_ERR_DATA);
  endtask

  task automatic test_gpio;
    logic [31:0]    rnd;
    mcu_pkg::word_t data;
    int             i;
    for (i = 0; i < 4; i++) begin
      rand_bits(`MCU_GPIO_W, rnd);
      bus_write(periph_reg(`MCU_REG_GPIO_OUT), rnd);
      check_eq("gpio_o", 32'(gpio_out), 32'(rnd[`MCU_GPIO_W-1:0]));
      rand_bits(`MCU_GPIO_W, rnd);
      bus_write(periph_reg(`MCU_REG_GPIO_OE), rnd);
      check_eq("gpio_oe_o", 32'(gpio_oe), 32'(rnd[`MCU_GPIO_W-1:0]));
      bus_read(periph_reg(`MCU_REG_GPIO_OE), data);
      check_eq("gpio_oe readback", data, 32'(rnd[`MCU_GPIO_W-1:0]));
    end
    for (i = 0; i < 4; i++) begin
      rand_bits(`MCU_GPIO_W, rnd);
      @(negedge clk);
      gpio_in = rnd[`MCU_GPIO_W-1:0];
      // Two synchronizer flops plus margin
      repeat (3) @(negedge clk);
      bus_read(periph_reg(`MCU_REG_GPIO_IN), data);
      check_eq("gpio_in readback", data, 32'(rnd[`MCU_GPIO_W-1:0]));
    end
  endtask

  task automatic test_exit;
    logic [31:0]    rnd;
    mcu_pkg::word_t data;
    rand_bits(32, rnd);
    bus_write(periph_reg(`MCU_REG_EXIT), rnd);
    check_eq("exit_value_o", exit_value, rnd);
    check_eq("exit_valid_o", 32'(exit_valid), 32'h1);
    bus_read(periph_reg(`MCU_REG_EXIT), data);
    check_eq("exit readback", data, rnd);
  endtask

  task automatic test_dma_copy;
    mcu_pkg::word_t src_data [DMA_WORDS];
    mcu_pkg::word_t guard;
    mcu_pkg::word_t data;
    int             i;
    for (i = 0; i < DMA_WORDS; i++) begin
      rand_bits(32, src_data[i]);
      bus_write(ram_addr(128 + i), src_data[i]);
    end
    rand_bits(32, guard);
    bus_write(ram_addr(192 + DMA_WORDS), guard);
    start_copy(128, 192, DMA_WORDS);
    bus_read(periph_reg(`MCU_REG_DMA_STATUS), data);
    check_eq("dma_status busy", data, 32'h1);
    // Shifted source, so a second copy would change the destination
    bus_write(periph_reg(`MCU_REG_DMA_SRC), 32'(ram_addr(128 + 1)));
    // Length write while busy is dropped
    bus_write(periph_reg(`MCU_REG_DMA_LEN), 4);
    bus_read(periph_reg(`MCU_REG_DMA_LEN), data);
    check_eq("dma_len", data, DMA_WORDS);
    wait_dma_idle();
    for (i = 0; i < DMA_WORDS; i++) begin
      bus_read(ram_addr(192 + i), data);
      check_eq("dma destination word", data, src_data[i]);
    end
    bus_read(ram_addr(192 + DMA_WORDS), data);
    check_eq("word past destination", data, guard);
    repeat (50) @(negedge clk);
    bus_read(periph_reg(`MCU_REG_DMA_STATUS), data);
    check_eq("dma_status idle", data, 32'h0);
    for (i = 0; i < DMA_WORDS; i++) begin
      bus_read(ram_addr(192 + i), data);
      check_eq("dma destination word", data, src_data[i]);
    end
  endtask

  task automatic test_contention;
    mcu_pkg::word_t src_data [DMA_WORDS];
    mcu_pkg::word_t host_data [DMA_WORDS];
    mcu_pkg::word_t data;
    int             i;
    for (i = 0; i < DMA_WORDS; i++) begin
      rand_bits(32, src_data[i]);
      bus_write(ram_addr(i), src_data[i]);
    end
    start_copy(0, 64, DMA_WORDS);
    bus_read(periph_reg(`MCU_REG_DMA_STATUS), data);
    check_eq("dma_status busy", data, 32'h1);
    // Host region 224..239 is disjoint from both copy regions
    for (i = 0; i < DMA_WORDS; i++) begin
      rand_bits(32, host_data[i]);
      bus_write(ram_addr(224 + i), host_data[i]);
    end
    for (i = 0; i < DMA_WORDS; i++) begin
      bus_read(ram_addr(224 + i), data);
      check_eq("host_rdata_o", data, host_data[i]);
    end
    wait_dma_idle();
    for (i = 0; i < DMA_WORDS; i++) begin
      bus_read(ram_addr(64 + i), data);
      check_eq("dma destination word", data, src_data[i]);
    end
  endtask

  initial begin
    lfsr_state = 32'h0bde86ce;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    gpio_in    = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    test_handshake();
    test_ram();
    test_gpio();
    test_exit();
    test_dma_copy();
    test_contention();
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("watchdog: the tests did not finish within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run timed out");
  end

endmodule

/* all.f */
+incdir+verilog
verilog/mcu_pkg.sv
verilog/bus_arbiter.sv
verilog/ram_bank.sv
verilog/ao_peripherals.sv
verilog/dma_engine.sv
verilog/mcu_top.sv
sim/tb_clock_gen.sv
sim/tb_mcu_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MCU testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_mcu_top \
  -o tb_mcu_top > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_mcu_top > sim.log 2>&1

grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || {
  echo "simulation failed, see sim.log"
  exit 1
}
